// File: rtl/dbus_pkg.sv
package dbus_pkg;

   localparam int RAM_WORDS       = 1024;
   localparam int RAM_ADDR_BITS   = $clog2(RAM_WORDS);
   localparam int IO_STALL_CYCLES = 2;
   localparam int IO_CNT_BITS     = $clog2(IO_STALL_CYCLES + 1);
   localparam int IRQ_SOURCES     = 4;
   localparam int GPIO_WIDTH      = 8;

   // system windows, compared against address bits 29 to 16
   localparam logic [13:0] PLIC_WINDOW  = 14'h0000;
   localparam logic [13:0] TIMER_WINDOW = 14'h0001;

   typedef struct packed {
      logic        ena;
      logic [3:0]  wstb;    // all zero for a read
      logic [31:0] addr;
      logic [31:0] wdata;
   } dbus_req_t;

   typedef struct packed {
      logic        stall;
      logic [31:0] rdata;
      logic        excpt;   // bad memory access
   } dbus_rsp_t;

   // narrow word bus for the system blocks
   typedef struct packed {
      logic        we;
      logic [3:0]  addr;    // word index
      logic [31:0] wdata;
   } sysbus_req_t;

   typedef enum logic [2:0] {
      REG_RAM,
      REG_IO,
      REG_PLIC,
      REG_TIMER,
      REG_NONE
   } region_e;

   typedef enum logic [1:0] {
      BR_IDLE,
      BR_ACCESS,
      BR_DONE
   } bridge_state_e;

endpackage

// File: rtl/dmem_region_decoder.sv
`timescale 1ns/1ps

module dmem_region_decoder import dbus_pkg::*; (
   input  dbus_req_t   req,
   output dbus_rsp_t   rsp,
   output dbus_req_t   ram_req,
   input  dbus_rsp_t   ram_rsp,
   output dbus_req_t   io_req,
   input  dbus_rsp_t   io_rsp,
   output sysbus_req_t plic_bus,
   input  logic [31:0] plic_rdata,
   output sysbus_req_t timer_bus,
   input  logic [31:0] timer_rdata
);

   region_e region;
   logic    sel_ram;
   logic    sel_io;
   logic    sel_plic;
   logic    sel_timer;

   // system blocks only see whole-word writes
   function automatic sysbus_req_t to_sysbus(dbus_req_t r);
      sysbus_req_t s;
      s.we    = r.ena & (|r.wstb);
      s.addr  = r.addr[5:2];
      s.wdata = r.wdata;
      return s;
   endfunction

   always_comb begin
      case (req.addr[31:30])
         2'b00:   region = REG_RAM;
         2'b10:   region = REG_IO;
         2'b11:   region = (req.addr[29:16] == PLIC_WINDOW)  ? REG_PLIC  :
                           (req.addr[29:16] == TIMER_WINDOW) ? REG_TIMER : REG_NONE;
         default: region = REG_NONE;   // region 01 is unmapped
      endcase
   end

   assign sel_ram   = req.ena && (region == REG_RAM);
   assign sel_io    = req.ena && (region == REG_IO);
   assign sel_plic  = req.ena && (region == REG_PLIC);
   assign sel_timer = req.ena && (region == REG_TIMER);

   // unselected targets get an all-zero request
   assign ram_req   = sel_ram   ? req            : '0;
   assign io_req    = sel_io    ? req            : '0;
   assign plic_bus  = sel_plic  ? to_sysbus(req) : '0;
   assign timer_bus = sel_timer ? to_sysbus(req) : '0;

   always_comb begin
      rsp = '0;
      if (req.ena) begin
         case (region)
            REG_RAM: begin
               rsp.stall = ram_rsp.stall;
               rsp.rdata = ram_rsp.rdata;
               rsp.excpt = ram_rsp.excpt & ~ram_rsp.stall;   // only on the completing cycle
            end
            REG_IO: begin
               rsp.stall = io_rsp.stall;
               rsp.rdata = io_rsp.rdata;
               rsp.excpt = io_rsp.excpt & ~io_rsp.stall;
            end
            REG_PLIC:  rsp.rdata = plic_rdata;
            REG_TIMER: rsp.rdata = timer_rdata;
            default:   rsp.excpt = 1'b1;   // completes at once with zero data
         endcase
      end
   end

   always_comb begin
      a_one_target: assert ($onehot0({ram_req.ena, io_req.ena, sel_plic, sel_timer}))
         else $error("more than one data target selected");
   end

endmodule

// File: rtl/dmem_ram.sv
`timescale 1ns/1ps

module dmem_ram import dbus_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  dbus_req_t req,
   output dbus_rsp_t rsp
);

   logic [31:0]              mem [RAM_WORDS];
   logic [31:0]              rdata_q;
   logic [RAM_ADDR_BITS-1:0] idx;
   logic                     phase;          // high in the cycle that completes the access
   logic                     out_of_range;
   logic                     wr_en;

   assign idx          = req.addr[RAM_ADDR_BITS+1:2];
   assign out_of_range = req.addr[31:2] >= 30'(RAM_WORDS);

   // writes land at the end of the completing cycle and never out of range
   assign wr_en = req.ena & phase & ~out_of_range & (|req.wstb);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         phase <= 1'b0;
      end else begin
         phase <= req.ena & ~phase;
      end
   end

   always_ff @(posedge clk) begin
      if (req.ena && !phase) begin
         rdata_q <= mem[idx];   // sampled during the stall cycle
      end
      for (int b = 0; b < 4; b++) begin
         if (wr_en && req.wstb[b]) begin
            mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
         end
      end
   end

   assign rsp.stall = req.ena & ~phase;
   assign rsp.rdata = rdata_q;
   assign rsp.excpt = req.ena & phase & out_of_range;

   a_no_excpt_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
      rsp.stall |-> !rsp.excpt)
      else $error("ram exception raised while stalling");

endmodule

// File: rtl/periph_bridge.sv
`timescale 1ns/1ps

module periph_bridge import dbus_pkg::*; (
   input  logic                  clk,
   input  logic                  arst_n,
   input  dbus_req_t             req,
   output dbus_rsp_t             rsp,
   input  logic [GPIO_WIDTH-1:0] gpio_in,
   output logic [GPIO_WIDTH-1:0] gpio_out
);

   bridge_state_e          state;
   logic [IO_CNT_BITS-1:0] cnt;            // stall cycles already spent
   logic [GPIO_WIDTH-1:0]  gpio_meta;
   logic [GPIO_WIDTH-1:0]  gpio_sync;
   logic [31:0]            scratch;
   logic [27:0]            offset;
   logic                   commit;

   assign offset = req.addr[29:2];
   assign commit = req.ena && (state == BR_DONE);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= BR_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            BR_IDLE: begin
               if (req.ena) begin
                  cnt   <= IO_CNT_BITS'(1);
                  state <= (IO_STALL_CYCLES > 1) ? BR_ACCESS : BR_DONE;
               end
            end
            BR_ACCESS: begin
               if (!req.ena) begin
                  state <= BR_IDLE;
               end else if (cnt == IO_CNT_BITS'(IO_STALL_CYCLES - 1)) begin
                  state <= BR_DONE;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: state <= BR_IDLE;   // done lasts a single cycle
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         gpio_out <= '0;
      end else if (commit && offset == 28'd0 && req.wstb[0]) begin
         gpio_out <= req.wdata[GPIO_WIDTH-1:0];
      end
   end

   always_ff @(posedge clk) begin
      gpio_meta <= gpio_in;   // two-flop synchronizer for the input pins
      gpio_sync <= gpio_meta;
      for (int b = 0; b < 4; b++) begin
         if (commit && offset == 28'd2 && req.wstb[b]) begin
            scratch[8*b +: 8] <= req.wdata[8*b +: 8];
         end
      end
   end

   always_comb begin
      rsp       = '0;
      rsp.stall = req.ena && (state != BR_DONE);
      case (offset)
         28'd0:   rsp.rdata = 32'(gpio_out);
         28'd1:   rsp.rdata = 32'(gpio_sync);
         28'd2:   rsp.rdata = scratch;
         default: rsp.rdata = '0;
      endcase
   end

   a_done_needs_ena: assert property (@(posedge clk) disable iff (!arst_n)
      state == BR_DONE |-> req.ena)
      else $error("bridge reached done without a held request");

endmodule

// File: rtl/irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl import dbus_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n,
   input  sysbus_req_t            bus,
   output logic [31:0]            rdata,
   input  logic [IRQ_SOURCES-1:0] irq_src,
   output logic                   irq_ext
);

   logic [IRQ_SOURCES-1:0] pending;
   logic [IRQ_SOURCES-1:0] enable;
   logic [IRQ_SOURCES-1:0] clear;

   // writing ones clears pending bits unless their source is still high
   assign clear = (bus.we && bus.addr == 4'd0) ? bus.wdata[IRQ_SOURCES-1:0] : '0;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending <= '0;
         enable  <= '0;
      end else begin
         pending <= (pending & ~clear) | irq_src;
         if (bus.we && bus.addr == 4'd1) begin
            enable <= bus.wdata[IRQ_SOURCES-1:0];
         end
      end
   end

   always_comb begin
      case (bus.addr)
         4'd0:    rdata = 32'(pending);
         4'd1:    rdata = 32'(enable);
         default: rdata = '0;
      endcase
   end

   assign irq_ext = |(pending & enable);

endmodule

// File: rtl/mach_timer.sv
`timescale 1ns/1ps

module mach_timer import dbus_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  sysbus_req_t bus,
   output logic [31:0] rdata,
   output logic        irq_timer
);

   logic [63:0] mtime;
   logic [63:0] mtimecmp;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mtime     <= '0;
         mtimecmp  <= '1;   // far future, so no interrupt out of reset
         irq_timer <= 1'b0;
      end else begin
         irq_timer <= (mtime >= mtimecmp);
         if (bus.we && bus.addr == 4'd0) begin
            mtime[31:0] <= bus.wdata;
         end else if (bus.we && bus.addr == 4'd1) begin
            mtime[63:32] <= bus.wdata;
         end else begin
            mtime <= mtime + 64'd1;
         end
         if (bus.we && bus.addr == 4'd2) begin
            mtimecmp[31:0] <= bus.wdata;
         end
         if (bus.we && bus.addr == 4'd3) begin
            mtimecmp[63:32] <= bus.wdata;
         end
      end
   end

   always_comb begin
      case (bus.addr)
         4'd0:    rdata = mtime[31:0];
         4'd1:    rdata = mtime[63:32];
         4'd2:    rdata = mtimecmp[31:0];
         4'd3:    rdata = mtimecmp[63:32];
         default: rdata = '0;
      endcase
   end

   a_mtime_step: assert property (@(posedge clk) disable iff (!arst_n)
      !(bus.we && bus.addr[3:1] == 3'd0) |=> mtime == $past(mtime) + 64'd1)
      else $error("mtime did not advance by one");

endmodule

// File: rtl/dbus_top.sv
`timescale 1ns/1ps

module dbus_top import dbus_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n,
   input  dbus_req_t              dmem_req,
   output dbus_rsp_t              dmem_rsp,
   input  logic [GPIO_WIDTH-1:0]  gpio_in,
   output logic [GPIO_WIDTH-1:0]  gpio_out,
   input  logic [IRQ_SOURCES-1:0] irq_src,
   output logic                   irq_ext,
   output logic                   irq_timer
);

   dbus_req_t   ram_req;
   dbus_rsp_t   ram_rsp;
   dbus_req_t   io_req;
   dbus_rsp_t   io_rsp;
   sysbus_req_t plic_bus;
   sysbus_req_t timer_bus;
   logic [31:0] plic_rdata;
   logic [31:0] timer_rdata;

   dmem_region_decoder decoder_i (
      .req         (dmem_req),
      .rsp         (dmem_rsp),
      .ram_req     (ram_req),
      .ram_rsp     (ram_rsp),
      .io_req      (io_req),
      .io_rsp      (io_rsp),
      .plic_bus    (plic_bus),
      .plic_rdata  (plic_rdata),
      .timer_bus   (timer_bus),
      .timer_rdata (timer_rdata)
   );

   dmem_ram ram_i (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (ram_req),
      .rsp    (ram_rsp)
   );

   periph_bridge bridge_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .req      (io_req),
      .rsp      (io_rsp),
      .gpio_in  (gpio_in),
      .gpio_out (gpio_out)
   );

   irq_ctrl plic_i (
      .clk     (clk),
      .arst_n  (arst_n),
      .bus     (plic_bus),
      .rdata   (plic_rdata),
      .irq_src (irq_src),
      .irq_ext (irq_ext)
   );

   mach_timer timer_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .bus       (timer_bus),
      .rdata     (timer_rdata),
      .irq_timer (irq_timer)
   );

endmodule

// File: verification/dbus_tb.sv
`timescale 1ns/1ps

module dbus_tb import dbus_pkg::*; ();

   localparam int          CLK_PERIOD  = 40;
   localparam int          SWEEP_WORDS = 16;
   localparam logic [31:0] SWEEP_BASE  = 32'h0000_0100;

   typedef struct packed {
      logic [15:0] line_no;
      logic [7:0]  op;
      logic [31:0] addr;
      logic [3:0]  wstb;
      logic [31:0] wdata;
      logic [31:0] exp_rdata;
      logic        exp_excpt;
      logic [31:0] mask;      // zero leaves rdata unchecked
   } trace_line_t;

   logic                   clk;
   logic                   arst_n;
   dbus_req_t              dmem_req;
   dbus_rsp_t              dmem_rsp;
   logic [GPIO_WIDTH-1:0]  gpio_in;
   logic [GPIO_WIDTH-1:0]  gpio_out;
   logic [IRQ_SOURCES-1:0] irq_src;
   logic                   irq_ext;
   logic                   irq_timer;

   trace_line_t trace_q[$];
   logic        trace_loaded;
   logic [31:0] rng;
   int          errors;
   int          checks;

   dbus_top dut_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .dmem_req  (dmem_req),
      .dmem_rsp  (dmem_rsp),
      .gpio_in   (gpio_in),
      .gpio_out  (gpio_out),
      .irq_src   (irq_src),
      .irq_ext   (irq_ext),
      .irq_timer (irq_timer)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // byte lanes with a strobe take the new data, the rest keep the old word
   function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                                logic [3:0] strb);
      logic [31:0] m;
      m = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) m[8*b +: 8] = new_w[8*b +: 8];
      end
      return m;
   endfunction

   task automatic check_rsp(string name, dbus_rsp_t exp, dbus_rsp_t act, logic [31:0] mask);
      checks++;
      if (act.excpt !== exp.excpt || (act.rdata & mask) !== (exp.rdata & mask)) begin
         errors++;
         $display("FAILED %s: expected rdata %h excpt %b, actual rdata %h excpt %b (mask %h)",
                  name, exp.rdata, exp.excpt, act.rdata, act.excpt, mask);
      end
   endtask

   task automatic check_irq(string name, logic [1:0] exp, logic [1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED %s: expected irq_ext/irq_timer %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_gpio(string name, logic [GPIO_WIDTH-1:0] exp,
                             logic [GPIO_WIDTH-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED %s: expected gpio_out %h, actual %h", name, exp, act);
      end
   endtask

   // starts and ends on a falling edge and keeps the request up through the completing edge
   task automatic bus_access(input dbus_req_t r, output dbus_rsp_t rsp);
      dmem_req = r;
      @(negedge clk);
      while (dmem_rsp.stall) @(negedge clk);
      rsp = dmem_rsp;
      @(negedge clk);
      dmem_req = '0;
      @(negedge clk);   // one idle cycle between accesses
   endtask

   task automatic load_trace();
      int          fd;
      int          lineno;
      int          n;
      string       line;
      trace_line_t t;
      logic [31:0] f_addr;
      logic [31:0] f_wstb;
      logic [31:0] f_wdata;
      logic [31:0] f_rdata;
      logic [31:0] f_excpt;
      logic [31:0] f_mask;
      logic [7:0]  f_op;
      lineno = 0;
      fd = $fopen("verification/dbus_trace.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("ERROR: the trace file could not be opened");
         return;
      end
      while ($fgets(line, fd) != 0) begin
         lineno++;
         if (line.len() < 2 || line[0] == "#") continue;
         n = $sscanf(line, "%c %h %h %h %h %h %h", f_op, f_addr, f_wstb, f_wdata,
                     f_rdata, f_excpt, f_mask);
         if (n != 7) begin
            errors++;
            $display("ERROR: trace line %0d could not be parsed", lineno);
            continue;
         end
         t = '{line_no: 16'(lineno), op: f_op, addr: f_addr, wstb: f_wstb[3:0],
               wdata: f_wdata, exp_rdata: f_rdata, exp_excpt: f_excpt[0], mask: f_mask};
         trace_q.push_back(t);
      end
      $fclose(fd);
   endtask

   task automatic run_line(trace_line_t t);
      dbus_req_t r;
      dbus_rsp_t rsp;
      dbus_rsp_t exp;
      string     name;
      name = $sformatf("trace line %0d (%c)", t.line_no, t.op);
      case (t.op)
         "W", "R": begin
            r.ena   = 1'b1;
            r.wstb  = (t.op == "W") ? t.wstb : 4'h0;
            r.addr  = t.addr;
            r.wdata = t.wdata;
            bus_access(r, rsp);
            exp       = '0;
            exp.rdata = t.exp_rdata;
            exp.excpt = t.exp_excpt;
            check_rsp(name, exp, rsp, t.mask);
         end
         "S": begin
            irq_src = t.wdata[IRQ_SOURCES-1:0];
            @(negedge clk);
         end
         "P": begin
            gpio_in = t.wdata[GPIO_WIDTH-1:0];
            repeat (3) @(negedge clk);   // covers the two synchronizer flops
         end
         "G": check_gpio(name, t.wdata[GPIO_WIDTH-1:0], gpio_out);
         "I": check_irq(name, t.wdata[1:0], {irq_ext, irq_timer});
         default: begin
            errors++;
            $display("ERROR: %s has an unknown operation", name);
         end
      endcase
   endtask

   task automatic ram_sweep();
      logic [31:0] shadow [SWEEP_WORDS];
      dbus_req_t   r;
      dbus_rsp_t   rsp;
      dbus_rsp_t   exp;
      for (int pass = 0; pass < 3; pass++) begin
         for (int i = 0; i < SWEEP_WORDS; i++) begin
            rng     = xorshift32(rng);
            r.ena   = 1'b1;
            r.addr  = SWEEP_BASE + 32'(4 * i);
            r.wdata = rng;
            r.wstb  = (pass == 0) ? 4'hf : (pass == 1) ? (rng[19:16] | 4'h1) : 4'h0;
            bus_access(r, rsp);
            if (pass == 0) shadow[i] = r.wdata;
            if (pass == 1) shadow[i] = merge_bytes(shadow[i], r.wdata, r.wstb);
            if (pass == 2) begin
               exp       = '0;
               exp.rdata = shadow[i];
               check_rsp($sformatf("sweep word %0d", i), exp, rsp, 32'hffff_ffff);
            end
         end
      end
   endtask

   initial begin
      errors       = 0;
      checks       = 0;
      trace_loaded = 1'b0;
      rng          = 32'h75dc_5118;
      arst_n       = 1'b0;
      dmem_req     = '0;
      gpio_in      = '0;
      irq_src      = '0;
      load_trace();
      trace_loaded = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      foreach (trace_q[i]) run_line(trace_q[i]);
      ram_sweep();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // budget of 20 cycles per trace line and per sweep access
   initial begin
      wait (trace_loaded);
      repeat (20 * (trace_q.size() + 3 * SWEEP_WORDS) + 8) @(posedge clk);
      $display("ERROR: the run hung and did not finish within its cycle budget");
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("Test failed");
      $finish;
   end

endmodule

// File: verification/dbus_trace.txt
# op addr wstb wdata exp_rdata exp_excpt mask, all hex, mask 0 leaves rdata unchecked
# W write, R read, S irq_src=wdata, P gpio_in=wdata, G gpio_out==wdata, I {ext,timer}==wdata
I 00000000 0 00000000 00000000 0 00000000
W 00000010 f a5a5a5a5 00000000 0 00000000
W 00000010 5 00ff00ff 00000000 0 00000000
R 00000010 0 00000000 a5ffa5ff 0 ffffffff
W 00000014 f 01234567 00000000 0 00000000
W 00000014 a cafebabe 00000000 0 00000000
R 00000014 0 00000000 ca23ba67 0 ffffffff
W 00000000 f 11223344 00000000 0 00000000
W 00001000 f deadbeef 00000000 1 00000000
R 00001000 0 00000000 00000000 1 00000000
R 00000000 0 00000000 11223344 0 ffffffff
R 40000000 0 00000000 00000000 1 ffffffff
W 40000010 f 12345678 00000000 1 ffffffff
R c0020000 0 00000000 00000000 1 ffffffff
W 80000000 1 0000005a 00000000 0 00000000
G 00000000 0 0000005a 00000000 0 00000000
R 80000000 0 00000000 0000005a 0 ffffffff
W 80000008 f 13579bdf 00000000 0 00000000
R 80000008 0 00000000 13579bdf 0 ffffffff
P 00000000 0 0000003c 00000000 0 00000000
R 80000004 0 00000000 0000003c 0 ffffffff
W 80000010 f ffffffff 00000000 0 00000000
R 80000010 0 00000000 00000000 0 ffffffff
S 00000000 0 00000004 00000000 0 00000000
R c0000000 0 00000000 00000004 0 ffffffff
I 00000000 0 00000000 00000000 0 00000000
W c0000004 f 00000004 00000000 0 00000000
I 00000000 0 00000002 00000000 0 00000000
S 00000000 0 00000000 00000000 0 00000000
W c0000000 f 00000004 00000000 0 00000000
R c0000000 0 00000000 00000000 0 ffffffff
I 00000000 0 00000000 00000000 0 00000000
W c001000c f 00000000 00000000 0 00000000
W c0010008 f 00000000 00000000 0 00000000
I 00000000 0 00000001 00000000 0 00000000
R c0010000 0 00000000 00000000 0 00000000

// File: sim.f
rtl/dbus_pkg.sv
rtl/dmem_region_decoder.sv
rtl/dmem_ram.sv
rtl/periph_bridge.sv
rtl/irq_ctrl.sv
rtl/mach_timer.sv
rtl/dbus_top.sv
verification/dbus_tb.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = dbus_tb
FLIST = sim.f
LOG   = sim.log

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
